// File: frame_check_sequence.sv
// Ethernet CRC-32 frame check sequence, one byte per cycle
`timescale 1ns/10ps

module frame_check_sequence (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    clear,
    input  udp_port_pkg::byte_t     data,
    input  logic                    data_enable,
    output udp_port_pkg::crc_t      crc
);

    udp_port_pkg::crc_t crc_state;

    // Reflected polynomial, LSB of the byte first
    function automatic udp_port_pkg::crc_t crc_step(udp_port_pkg::crc_t crc_in,
                                                    udp_port_pkg::byte_t data_in);
        udp_port_pkg::crc_t next;
        next = crc_in ^ {24'h000000, data_in};
        for (int i = 0; i < 8; i++) begin
            next = next[0] ? ((next >> 1) ^ 32'hEDB88320) : (next >> 1);
        end
        return next;
    endfunction

    always_ff @(posedge clock) begin
        if (!rst_n || clear) begin
            crc_state <= '1;
        end else if (data_enable) begin
            crc_state <= crc_step(crc_state, data);
        end
    end

    assign crc = ~crc_state;

endmodule

// File: frame_generator.sv
// Frame generator that wraps each stored payload in Ethernet, IPv4 and UDP headers plus FCS
`timescale 1ns/10ps
`include "udp_port_config.svh"

module frame_generator (
    input  logic                    clock,
    input  logic                    rst_n,
    payload_if.generator            payload,
    input  udp_port_pkg::mac_t      mac_destination,
    input  udp_port_pkg::mac_t      mac_source,
    input  udp_port_pkg::ipv4_t     ipv4_destination,
    input  udp_port_pkg::ipv4_t     ipv4_source,
    input  udp_port_pkg::port_t     udp_source_port,
    input  udp_port_pkg::port_t     udp_destination_port,
    input  logic                    transmit_full,
    output udp_port_pkg::stream_t   frame_data,
    output logic                    frame_data_valid
);

    localparam int          CHECKSUM_WORDS = `IPV4_HEADER_BYTES / 2;
    localparam logic [7:0]  PROTOCOL_UDP   = 8'd17;

    udp_port_pkg::frame_state_t         state;
    udp_port_pkg::length_t              payload_length;
    udp_port_pkg::length_t              byte_index;
    udp_port_pkg::length_t              total_length;
    udp_port_pkg::length_t              udp_length;
    udp_port_pkg::checksum_t            header_checksum;
    udp_port_pkg::crc_t                 fcs;
    udp_port_pkg::byte_t                header_byte;
    logic [15:0]                        identification;
    logic [79:0]                        ipv4_fixed;
    logic [8*`IPV4_HEADER_BYTES-1:0]    checksum_words;
    logic [8*`HEADER_BYTES-1:0]         header;
    logic                               emit;
    logic                               last_byte;

    //////////////////////////////
    // Header fields
    //////////////////////////////

    assign total_length = payload_length + 16'(`IPV4_HEADER_BYTES + `UDP_HEADER_BYTES);
    assign udp_length   = payload_length + 16'(`UDP_HEADER_BYTES);

    // Version/IHL through protocol
    assign ipv4_fixed = {8'h45, 8'h00, total_length, identification, `IPV4_FLAGS,
                         8'(`IPV4_TTL), PROTOCOL_UDP};

    assign checksum_words = {ipv4_fixed, 16'h0000, ipv4_source, ipv4_destination};

    assign header = {mac_destination, mac_source, `ETHERTYPE_IPV4,
                     ipv4_fixed, header_checksum, ipv4_source, ipv4_destination,
                     udp_source_port, udp_destination_port, udp_length, 16'h0000};

    assign header_byte = header[(`HEADER_BYTES - 1 - byte_index) * 8 +: 8];

    //////////////////////////////
    // Byte output
    //////////////////////////////

    always_comb begin
        case (state)
            udp_port_pkg::HEADER,
            udp_port_pkg::FCS:     emit = !transmit_full;
            udp_port_pkg::PAYLOAD: emit = !transmit_full && payload.data_valid;
            default:               emit = 1'b0;
        endcase
    end

    assign last_byte = (state == udp_port_pkg::FCS) && (byte_index == 16'(`FCS_BYTES - 1));

    always_comb begin
        case (state)
            udp_port_pkg::PAYLOAD: frame_data = {1'b0, payload.data};
            udp_port_pkg::FCS:     frame_data = {last_byte, fcs[byte_index[1:0] * 8 +: 8]};
            default:               frame_data = {1'b0, header_byte};
        endcase
    end

    assign frame_data_valid = emit;
    assign payload.start    = (state == udp_port_pkg::IDLE) && payload.packet_pending;
    assign payload.read     = (state == udp_port_pkg::PAYLOAD) && emit;

    always_ff @(posedge clock) begin
        if (payload.start) begin
            payload_length <= payload.length;
        end
    end

    //////////////////////////////
    // FSM
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state          <= udp_port_pkg::IDLE;
            byte_index     <= '0;
            identification <= '0;
        end else begin
            case (state)
                udp_port_pkg::IDLE: begin
                    byte_index <= '0;
                    if (payload.packet_pending) begin
                        state <= udp_port_pkg::CHECKSUM;
                    end
                end
                udp_port_pkg::CHECKSUM: begin
                    // Ten header words, then one cycle for the result register
                    if (byte_index == 16'(CHECKSUM_WORDS)) begin
                        state      <= udp_port_pkg::HEADER;
                        byte_index <= '0;
                    end else begin
                        byte_index <= byte_index + 1'b1;
                    end
                end
                udp_port_pkg::HEADER: begin
                    if (emit && byte_index == 16'(`HEADER_BYTES - 1)) begin
                        state      <= udp_port_pkg::PAYLOAD;
                        byte_index <= '0;
                    end else if (emit) begin
                        byte_index <= byte_index + 1'b1;
                    end
                end
                udp_port_pkg::PAYLOAD: begin
                    if (emit && byte_index == payload_length - 1'b1) begin
                        state      <= udp_port_pkg::FCS;
                        byte_index <= '0;
                    end else if (emit) begin
                        byte_index <= byte_index + 1'b1;
                    end
                end
                udp_port_pkg::FCS: begin
                    if (emit && last_byte) begin
                        state          <= udp_port_pkg::IDLE;
                        identification <= identification + 1'b1;
                    end else if (emit) begin
                        byte_index <= byte_index + 1'b1;
                    end
                end
                default: state <= udp_port_pkg::IDLE;
            endcase
        end
    end

    internet_checksum ipv4_checksum (
        .clock          (clock),
        .rst_n          (rst_n),
        .clear          (state == udp_port_pkg::IDLE),
        .word_in        (checksum_words[(CHECKSUM_WORDS - 1 - byte_index) * 16 +: 16]),
        .word_enable    ((state == udp_port_pkg::CHECKSUM) && (byte_index < 16'(CHECKSUM_WORDS))),
        .result         (header_checksum)
    );

    // Covers every byte before the FCS itself
    frame_check_sequence fcs_generator (
        .clock          (clock),
        .rst_n          (rst_n),
        .clear          (state == udp_port_pkg::IDLE),
        .data           (frame_data[7:0]),
        .data_enable    (emit && (state != udp_port_pkg::FCS)),
        .crc            (fcs)
    );

endmodule

// File: internet_checksum.sv
// IPv4 header checksum as a ones complement sum of 16-bit words
`timescale 1ns/10ps

module internet_checksum (
    input  logic                        clock,
    input  logic                        rst_n,
    input  logic                        clear,
    input  udp_port_pkg::checksum_t     word_in,
    input  logic                        word_enable,
    output udp_port_pkg::checksum_t     result
);

    logic [16:0]                sum;
    udp_port_pkg::checksum_t    folded;

    // Carry out of bit 15 wraps back in on the next word
    always_ff @(posedge clock) begin
        if (!rst_n || clear) begin
            sum <= '0;
        end else if (word_enable) begin
            sum <= {1'b0, sum[15:0]} + {16'h0000, sum[16]} + {1'b0, word_in};
        end
    end

    assign folded = sum[15:0] + {15'h0000, sum[16]};

    always_ff @(posedge clock) begin
        result <= ~folded;                  // Valid one cycle after the final word
    end

endmodule

// File: payload_buffer.sv
// Payload buffer that stores fabric payload bytes and queues packet lengths
`timescale 1ns/10ps
`include "udp_port_config.svh"

module payload_buffer (
    input  logic                    clock,
    input  logic                    rst_n,
    input  udp_port_pkg::stream_t   module_transmit_data,
    input  logic                    module_transmit_data_enable,
    output logic                    module_transmit_ready,
    payload_if.buffer               payload
);

    udp_port_pkg::length_t  byte_count;
    logic                   accept;
    logic                   packet_end;
    logic                   byte_full;
    logic                   byte_empty;
    logic                   length_full;
    logic                   length_empty;

    assign accept                = module_transmit_data_enable && module_transmit_ready;
    assign packet_end            = accept && module_transmit_data[8];
    assign module_transmit_ready = !byte_full && !length_full;

    // Bytes of the packet still arriving
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            byte_count <= '0;
        end else if (packet_end) begin
            byte_count <= '0;
        end else if (accept) begin
            byte_count <= byte_count + 1'b1;
        end
    end

    sync_fifo #(
        .WIDTH  (8),
        .DEPTH  (`PAYLOAD_DEPTH)
    ) byte_fifo (
        .clock          (clock),
        .rst_n          (rst_n),
        .write_data     (module_transmit_data[7:0]),
        .write_enable   (accept),
        .read_enable    (payload.read),
        .read_data      (payload.data),
        .empty          (byte_empty),
        .full           (byte_full)
    );

    sync_fifo #(
        .WIDTH  (16),
        .DEPTH  (`LENGTH_SLOTS)
    ) length_fifo (
        .clock          (clock),
        .rst_n          (rst_n),
        .write_data     (byte_count + 1'b1),       // Count includes the last byte
        .write_enable   (packet_end),
        .read_enable    (payload.start),
        .read_data      (payload.length),
        .empty          (length_empty),
        .full           (length_full)
    );

    assign payload.packet_pending = !length_empty;
    assign payload.data_valid     = !byte_empty;

endmodule

// File: payload_if.sv
// Payload handoff between the payload buffer and the frame generator
`timescale 1ns/10ps

interface payload_if;

    udp_port_pkg::length_t  length;             // Byte count of head packet
    logic                   packet_pending;
    logic                   start;              // Pops the length entry
    udp_port_pkg::byte_t    data;               // First word fall through
    logic                   data_valid;
    logic                   read;

    modport buffer (
        output length,
        output packet_pending,
        output data,
        output data_valid,
        input  start,
        input  read
    );

    modport generator (
        input  length,
        input  packet_pending,
        input  data,
        input  data_valid,
        output start,
        output read
    );

endinterface

// File: project.f
+incdir+.
udp_port_pkg.sv
payload_if.sv
sync_fifo.sv
payload_buffer.sv
internet_checksum.sv
frame_check_sequence.sv
frame_generator.sv
udp_port_top.sv
udp_port_assertions.sv
udp_port_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module udp_port_tb -f project.f \
    -o udp_port_sim
./obj_dir/udp_port_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "CHECKS FAILED" sim.log || ! grep -q "ALL CHECKS PASSED" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

// File: sync_fifo.sv
// Single clock FIFO with first word fall through read data
`timescale 1ns/10ps

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16
) (
    input  logic                clock,
    input  logic                rst_n,
    input  logic [WIDTH-1:0]    write_data,
    input  logic                write_enable,
    input  logic                read_enable,
    output logic [WIDTH-1:0]    read_data,
    output logic                empty,
    output logic                full
);

    localparam int ADDR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WIDTH-1:0]       memory [DEPTH];
    logic [ADDR_WIDTH-1:0]  write_pointer;
    logic [ADDR_WIDTH-1:0]  read_pointer;
    logic [ADDR_WIDTH:0]    count;
    logic                   push;
    logic                   pop;

    assign push = write_enable && !full;      // Writes to a full FIFO are dropped
    assign pop  = read_enable && !empty;

    always_ff @(posedge clock) begin
        if (push) begin
            memory[write_pointer] <= write_data;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            write_pointer <= '0;
            read_pointer  <= '0;
            count         <= '0;
        end else begin
            if (push) begin
                write_pointer <= (write_pointer == ADDR_WIDTH'(DEPTH - 1)) ?
                                 '0 : write_pointer + ADDR_WIDTH'(1);
            end
            if (pop) begin
                read_pointer <= (read_pointer == ADDR_WIDTH'(DEPTH - 1)) ?
                                '0 : read_pointer + ADDR_WIDTH'(1);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign read_data = memory[read_pointer];
    assign empty     = (count == '0);
    assign full      = (count == (ADDR_WIDTH + 1)'(DEPTH));

endmodule

// File: udp_port_assertions.sv
// Handshake and reset assertions for the UDP transmit port, bound to the top level
`timescale 1ns/10ps

module udp_port_assertions (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    module_transmit_data_enable,
    input  logic                    module_transmit_ready,
    input  udp_port_pkg::stream_t   transmit_data,
    input  logic                    transmit_data_valid,
    input  logic                    transmit_data_enable
);

    // Source holds off while the buffer is full
    write_only_when_ready: assert property (
        @(posedge clock) disable iff (!rst_n)
        module_transmit_data_enable |-> module_transmit_ready
    ) else $error("Write offered while module_transmit_ready is low");

    head_word_held: assert property (
        @(posedge clock) disable iff (!rst_n)
        (transmit_data_valid && !transmit_data_enable) |=>
            (transmit_data_valid && $stable(transmit_data))
    ) else $error("transmit_data changed without a pop");

    valid_low_in_reset: assert property (
        @(posedge clock) !rst_n |=> !transmit_data_valid
    ) else $error("transmit_data_valid high during reset");

endmodule

bind udp_port_top udp_port_assertions assertions_i (
    .clock                          (clock),
    .rst_n                          (rst_n),
    .module_transmit_data_enable    (module_transmit_data_enable),
    .module_transmit_ready          (module_transmit_ready),
    .transmit_data                  (transmit_data),
    .transmit_data_valid            (transmit_data_valid),
    .transmit_data_enable           (transmit_data_enable)
);

// File: udp_port_config.svh
// UDP transmit port sizes and fixed protocol constants
`ifndef UDP_PORT_CONFIG_SVH
`define UDP_PORT_CONFIG_SVH

// Buffering
`define PAYLOAD_DEPTH       2048
`define LENGTH_SLOTS        4
`define TRANSMIT_DEPTH      64

// Fixed header fields
`define IPV4_TTL            64
`define IPV4_FLAGS          16'h4000        // Don't fragment
`define ETHERTYPE_IPV4      16'h0800

`define IPV4_HEADER_BYTES   20
`define UDP_HEADER_BYTES    8
`define HEADER_BYTES        42              // Ethernet + IPv4 + UDP
`define FCS_BYTES           4
`endif

// File: udp_port_pkg.sv
// UDP transmit port shared types
package udp_port_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [8:0]  stream_t;      // Bit 8 marks last byte

    // Address and field widths
    typedef logic [47:0] mac_t;
    typedef logic [31:0] ipv4_t;
    typedef logic [15:0] port_t;
    typedef logic [15:0] length_t;
    typedef logic [15:0] checksum_t;
    typedef logic [31:0] crc_t;

    typedef enum logic [2:0] {
        IDLE,
        CHECKSUM,
        HEADER,
        PAYLOAD,
        FCS
    } frame_state_t;

endpackage

// File: udp_port_tb.sv
// Testbench for the UDP transmit port with a reference frame model and byte checker
`timescale 1ns/10ps
`include "udp_port_config.svh"

module udp_port_tb;

    localparam logic [31:0]         SEED               = 32'h9e8a6de2;
    localparam int                  TIMEOUT_CYCLES     = 20000;
    localparam int                  BURST_PACKET_BYTES = 100;
    localparam int                  DRAIN_OFF          = 0;
    localparam int                  DRAIN_ON           = 1;
    localparam int                  DRAIN_GAPS         = 2;
    localparam udp_port_pkg::mac_t  MAC_SOURCE         = 48'h02_11_22_33_44_55;
    localparam udp_port_pkg::mac_t  MAC_DESTINATION    = 48'h02_aa_bb_cc_dd_ee;
    localparam udp_port_pkg::ipv4_t IPV4_SOURCE        = 32'hc0a8_0a01;
    localparam udp_port_pkg::ipv4_t IPV4_DESTINATION   = 32'hc0a8_0a02;
    localparam udp_port_pkg::port_t UDP_SOURCE         = 16'd5000;
    localparam udp_port_pkg::port_t UDP_DESTINATION    = 16'd6000;

    logic                   clock;
    logic                   rst_n;
    udp_port_pkg::stream_t  module_transmit_data;
    logic                   module_transmit_data_enable;
    logic                   module_transmit_ready;
    udp_port_pkg::stream_t  transmit_data;
    logic                   transmit_data_valid;
    logic                   transmit_data_enable;

    logic [31:0]            lfsr_state;
    int                     drain_mode;
    int                     accepted;
    logic [15:0]            next_id;
    logic                   gap_bits [$];
    udp_port_pkg::byte_t    payload_q [$];
    udp_port_pkg::byte_t    frame_q [$];
    udp_port_pkg::stream_t  expected_q [$];

    udp_port_top dut_i (
        .clock                          (clock),
        .rst_n                          (rst_n),
        .mac_source                     (MAC_SOURCE),
        .mac_destination                (MAC_DESTINATION),
        .ipv4_source                    (IPV4_SOURCE),
        .ipv4_destination               (IPV4_DESTINATION),
        .udp_source_port                (UDP_SOURCE),
        .udp_destination_port           (UDP_DESTINATION),
        .module_transmit_data           (module_transmit_data),
        .module_transmit_data_enable    (module_transmit_data_enable),
        .module_transmit_ready          (module_transmit_ready),
        .transmit_data                  (transmit_data),
        .transmit_data_valid            (transmit_data_valid),
        .transmit_data_enable           (transmit_data_enable)
    );

    always #5 clock = ~clock;

    //////////////////////////////
    // Random source and reporting
    //////////////////////////////

    // Taps 32, 22, 2, 1
    function automatic logic random_bit();
        logic feedback;
        feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], feedback};
        return feedback;
    endfunction

    function automatic logic [31:0] random_value(input int bits);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < bits; i++) begin
            value = {value[30:0], random_bit()};
        end
        return value;
    endfunction

    task automatic stop_on_error();
        $display("CHECKS FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic report_error(input string reason);
        $display("Error at %0t ns: %s", $time, reason);
        stop_on_error();
    endtask

    task automatic compare_byte(input string name, input udp_port_pkg::byte_t actual,
                                input udp_port_pkg::byte_t expected);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            stop_on_error();
        end
    endtask

    task automatic compare_last(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
            stop_on_error();
        end
    endtask

    //////////////////////////////
    // Reference frame model
    //////////////////////////////

    function automatic udp_port_pkg::checksum_t reference_checksum(
            input udp_port_pkg::length_t total_length, input logic [15:0] id);
        logic [31:0] sum;
        sum = 32'h4500 + total_length + id + `IPV4_FLAGS + {8'(`IPV4_TTL), 8'd17}
            + IPV4_SOURCE[31:16] + IPV4_SOURCE[15:0]
            + IPV4_DESTINATION[31:16] + IPV4_DESTINATION[15:0];
        sum = sum[15:0] + sum[31:16];
        sum = sum[15:0] + sum[31:16];
        return ~sum[15:0];
    endfunction

    // Bit serial, LSB of each byte first
    function automatic udp_port_pkg::crc_t reference_crc();
        udp_port_pkg::crc_t  crc;
        udp_port_pkg::byte_t value;
        logic                feedback;
        crc = 32'hffff_ffff;
        foreach (frame_q[i]) begin
            value = frame_q[i];
            for (int b = 0; b < 8; b++) begin
                feedback = crc[0] ^ value[b];
                crc      = crc >> 1;
                if (feedback) begin
                    crc = crc ^ 32'hedb8_8320;
                end
            end
        end
        return ~crc;
    endfunction

    function automatic void append_field(input logic [47:0] value, input int count);
        for (int i = count - 1; i >= 0; i--) begin
            frame_q.push_back(value[8*i +: 8]);
        end
    endfunction

    // Expected frame for payload_q with the given identification
    function automatic void build_expected(input logic [15:0] id);
        udp_port_pkg::length_t total_length;
        udp_port_pkg::length_t udp_length;
        udp_port_pkg::crc_t    crc;
        total_length = 16'(payload_q.size() + `IPV4_HEADER_BYTES + `UDP_HEADER_BYTES);
        udp_length   = 16'(payload_q.size() + `UDP_HEADER_BYTES);
        frame_q.delete();
        append_field(MAC_DESTINATION, 6);
        append_field(MAC_SOURCE, 6);
        append_field(`ETHERTYPE_IPV4, 2);
        append_field(16'h4500, 2);
        append_field(total_length, 2);
        append_field(id, 2);
        append_field(`IPV4_FLAGS, 2);
        append_field(`IPV4_TTL, 1);
        append_field(17, 1);                // UDP
        append_field(reference_checksum(total_length, id), 2);
        append_field(IPV4_SOURCE, 4);
        append_field(IPV4_DESTINATION, 4);
        append_field(UDP_SOURCE, 2);
        append_field(UDP_DESTINATION, 2);
        append_field(udp_length, 2);
        append_field(0, 2);                 // UDP checksum unused
        foreach (payload_q[i]) begin
            frame_q.push_back(payload_q[i]);
        end
        crc = reference_crc();
        foreach (frame_q[i]) begin
            expected_q.push_back({1'b0, frame_q[i]});
        end
        for (int i = 0; i < `FCS_BYTES; i++) begin
            expected_q.push_back({i == `FCS_BYTES - 1, crc[8*i +: 8]});
        end
    endfunction

    //////////////////////////////
    // Stimulus and waits
    //////////////////////////////

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        while (!module_transmit_ready) begin
            module_transmit_data_enable = 1'b0;
            @(posedge clock);
            #1;
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                report_error("module_transmit_ready stayed low");
            end
        end
    endtask

    task automatic send_packet(input int length);
        payload_q.delete();
        for (int i = 0; i < length; i++) begin
            payload_q.push_back(udp_port_pkg::byte_t'(random_value(8)));
        end
        build_expected(next_id);
        next_id++;
        for (int i = 0; i < length; i++) begin
            wait_ready();
            module_transmit_data        = {i == length - 1, payload_q[i]};
            module_transmit_data_enable = 1'b1;
            @(posedge clock);
            #1;
        end
        module_transmit_data_enable = 1'b0;
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (expected_q.size() != 0) begin
            @(posedge clock);
            #1;
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                report_error("expected frames did not come out");
            end
        end
        repeat (4) @(posedge clock);
        #1;
        if (transmit_data_valid) begin
            report_error("extra output word after all expected frames");
        end
    endtask

    // Pops and checks the head word that the next edge removes
    always begin
        @(posedge clock);
        #1;
        case (drain_mode)
            DRAIN_OFF: transmit_data_enable = 1'b0;
            DRAIN_ON:  transmit_data_enable = 1'b1;
            default:   transmit_data_enable = (gap_bits.size() == 0) ? 1'b1 :
                                              gap_bits.pop_front();
        endcase
        if (rst_n && transmit_data_valid && transmit_data_enable) begin
            if (expected_q.size() == 0) begin
                report_error("output word arrived with no frame expected");
            end
            compare_byte("transmit_data[7:0]", transmit_data[7:0], expected_q[0][7:0]);
            compare_last("transmit_data[8]", transmit_data[8], expected_q[0][8]);
            void'(expected_q.pop_front());
        end
    end

    initial begin
        clock                       = 1'b0;
        rst_n                       = 1'b0;
        module_transmit_data        = '0;
        module_transmit_data_enable = 1'b0;
        transmit_data_enable        = 1'b0;
        lfsr_state                  = SEED;
        drain_mode                  = DRAIN_OFF;
        next_id                     = '0;
        repeat (4) @(posedge clock);
        #1;
        rst_n = 1'b1;
        @(posedge clock);
        #1;
        if (!module_transmit_ready) begin
            report_error("module_transmit_ready low after reset");
        end

        // Single short frame
        drain_mode = DRAIN_ON;
        send_packet(20);
        wait_drained();

        // Back to back random lengths
        for (int i = 0; i < 8; i++) begin
            send_packet(1 + int'(random_value(8) % 200));
        end
        wait_drained();

        // Random gaps on the output pop
        for (int i = 0; i < 3000; i++) begin
            gap_bits.push_back(random_bit());
        end
        drain_mode = DRAIN_GAPS;
        for (int i = 0; i < 6; i++) begin
            send_packet(1 + int'(random_value(8) % 200));
        end
        wait_drained();

        // Output blocked until the buffer fills
        drain_mode = DRAIN_OFF;
        accepted   = 0;
        while (module_transmit_ready && accepted < `LENGTH_SLOTS + 1) begin
            send_packet(BURST_PACKET_BYTES);
            accepted++;
        end
        if (module_transmit_ready) begin
            report_error("module_transmit_ready stayed high with the output blocked");
        end
        drain_mode = DRAIN_ON;
        wait_drained();

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: udp_port_top.sv
// UDP virtual port transmit path from fabric payload to switch frames
`timescale 1ns/10ps
`include "udp_port_config.svh"

module udp_port_top (
    input  logic                    clock,
    input  logic                    rst_n,
    input  udp_port_pkg::mac_t      mac_source,
    input  udp_port_pkg::mac_t      mac_destination,
    input  udp_port_pkg::ipv4_t     ipv4_source,
    input  udp_port_pkg::ipv4_t     ipv4_destination,
    input  udp_port_pkg::port_t     udp_source_port,
    input  udp_port_pkg::port_t     udp_destination_port,
    input  udp_port_pkg::stream_t   module_transmit_data,         // From fabric module
    input  logic                    module_transmit_data_enable,
    output logic                    module_transmit_ready,
    output udp_port_pkg::stream_t   transmit_data,                // To switch
    output logic                    transmit_data_valid,
    input  logic                    transmit_data_enable
);

    payload_if              payload ();
    udp_port_pkg::stream_t  frame_data;
    logic                   frame_data_valid;
    logic                   transmit_full;
    logic                   transmit_empty;

    payload_buffer payload_buffer_i (
        .clock                          (clock),
        .rst_n                          (rst_n),
        .module_transmit_data           (module_transmit_data),
        .module_transmit_data_enable    (module_transmit_data_enable),
        .module_transmit_ready          (module_transmit_ready),
        .payload                        (payload)
    );

    frame_generator frame_generator_i (
        .clock                  (clock),
        .rst_n                  (rst_n),
        .payload                (payload),
        .mac_destination        (mac_destination),
        .mac_source             (mac_source),
        .ipv4_destination       (ipv4_destination),
        .ipv4_source            (ipv4_source),
        .udp_source_port        (udp_source_port),
        .udp_destination_port   (udp_destination_port),
        .transmit_full          (transmit_full),
        .frame_data             (frame_data),
        .frame_data_valid       (frame_data_valid)
    );

    sync_fifo #(
        .WIDTH  (9),
        .DEPTH  (`TRANSMIT_DEPTH)
    ) transmit_fifo (
        .clock          (clock),
        .rst_n          (rst_n),
        .write_data     (frame_data),
        .write_enable   (frame_data_valid),
        .read_enable    (transmit_data_enable),
        .read_data      (transmit_data),
        .empty          (transmit_empty),
        .full           (transmit_full)
    );

    assign transmit_data_valid = !transmit_empty;

endmodule
